// ==== flist.f ====
+incdir+hdl
hdl/uart_mmio_pkg.sv
hdl/buf_mem_if.sv
hdl/uart_bit_rx.sv
hdl/rx_byte_packer.sv
hdl/host_wb_port.sv
hdl/buffer_arbiter.sv
hdl/rx_buffer_ram.sv
hdl/uart_rx_mmio.sv
verification/uart_rx_mmio_tb.sv

// ==== hdl/buf_mem_if.sv ====
`timescale 1ns/1ns

interface buf_mem_if import uart_mmio_pkg::*;
();

    logic       req;
    logic       we;
    word_idx_t  addr;
    logic [3:0] be;
    rx_word_u   wdata;
    logic       gnt;
    rx_word_u   rdata;

    // request fields stay put until gnt, rdata follows gnt by one cycle
    modport requester (
        output req, we, addr, be, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, be, wdata,
        output gnt, rdata
    );

endinterface

// ==== hdl/buffer_arbiter.sv ====
`timescale 1ns/1ns

module buffer_arbiter import uart_mmio_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    buf_mem_if.arbiter  rx_side,
    buf_mem_if.arbiter  host_side,
    output logic        ram_en,
    output logic        ram_we,
    output word_idx_t   ram_addr,
    output logic [3:0]  ram_be,
    output rx_word_u    ram_wdata,
    input  logic [31:0] ram_rdata
);

    // packer always wins, host retries next cycle
    assign rx_side.gnt   = rx_side.req;
    assign host_side.gnt = host_side.req && !rx_side.req;

    assign ram_en = rx_side.req || host_side.req;

    always_comb begin
        if (rx_side.req) begin
            ram_we    = rx_side.we;
            ram_addr  = rx_side.addr;
            ram_be    = rx_side.be;
            ram_wdata = rx_side.wdata;
        end else begin
            ram_we    = host_side.we;
            ram_addr  = host_side.addr;
            ram_be    = host_side.be;
            ram_wdata = host_side.wdata;
        end
    end

    // read data goes to both, only the host looks at it
    assign rx_side.rdata   = ram_rdata;
    assign host_side.rdata = ram_rdata;

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_side.gnt && host_side.gnt));

    // a host stalled behind the packer keeps its request steady
    a_host_holds: assert property (@(posedge clk) disable iff (!rst_n)
        host_side.req && !host_side.gnt |=>
            host_side.req && $stable(host_side.addr));

endmodule

// ==== hdl/host_wb_port.sv ====
`timescale 1ns/1ns
`include "uart_mmio_macros.svh"

module host_wb_port import uart_mmio_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  logic [31:0]  wb_adr,
    input  logic [31:0]  wb_wdata,
    input  logic [3:0]   wb_sel,
    output logic [31:0]  wb_rdata,
    output logic         wb_ack,
    buf_mem_if.requester mem,
    input  byte_tail_t   tail,
    input  wrap_count_t  wrap_count
);

    localparam logic [1:0] H_IDLE = 2'd0;
    localparam logic [1:0] H_REQ  = 2'd1;
    localparam logic [1:0] H_DATA = 2'd2;

    logic [1:0] state;
    logic       access;
    logic       is_buf;

    assign access = wb_cyc && wb_stb && !wb_ack;
    assign is_buf = !wb_adr[`TAIL_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= H_IDLE;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            case (state)
                H_IDLE: begin
                    if (access && is_buf && !wb_we) begin
                        state <= H_REQ;
                    end else if (access) begin
                        // registers and all writes answer right away
                        wb_ack <= 1'b1;
                    end
                end
                H_REQ: begin
                    if (mem.gnt) begin
                        state <= H_DATA;
                    end
                end
                H_DATA: begin
                    wb_ack <= 1'b1;
                    state  <= H_IDLE;
                end
                default: state <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == H_DATA) begin
            wb_rdata <= mem.rdata.word;
        end else if (state == H_IDLE && access) begin
            if (wb_adr == `REG_TAIL_ADDR) begin
                wb_rdata <= {{(32 - `TAIL_W){1'b0}}, tail};
            end else if (wb_adr == `REG_COUNT_ADDR) begin
                wb_rdata <= wrap_count;
            end else begin
                wb_rdata <= '0;
            end
        end
    end

    // read only, wdata stays zero
    assign mem.req   = (state == H_REQ);
    assign mem.we    = 1'b0;
    assign mem.addr  = wb_adr[`BUF_WORD_AW+1:2];
    assign mem.be    = 4'b0000;
    assign mem.wdata = '0;

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb);

    // writes are dropped but the master still has to drive a clean beat
    a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_stb && wb_we |-> !$isunknown({wb_sel, wb_wdata}));

endmodule

// ==== hdl/rx_buffer_ram.sv ====
`timescale 1ns/1ns
`include "uart_mmio_macros.svh"

module rx_buffer_ram import uart_mmio_pkg::*; (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  word_idx_t   addr,
    input  logic [3:0]  be,
    input  rx_word_u    wdata,
    output logic [31:0] rdata
);

    // contents start out zero
    rx_word_u mem [`BUF_WORDS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem[addr].lanes[i] <= wdata.lanes[i];
                    end
                end
            end else begin
                rdata <= mem[addr].word;
            end
        end
    end

endmodule

// ==== hdl/rx_byte_packer.sv ====
`timescale 1ns/1ns
`include "uart_mmio_macros.svh"

module rx_byte_packer import uart_mmio_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [7:0]   rx_byte,
    input  logic         byte_valid,
    buf_mem_if.requester mem,
    output byte_tail_t   tail,
    output wrap_count_t  wrap_count
);

    logic       pending;
    logic [7:0] byte_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            tail       <= '0;
            wrap_count <= '0;
        end else begin
            if (byte_valid) begin
                pending <= 1'b1;
            end else if (mem.gnt) begin
                pending <= 1'b0;
            end
            if (mem.gnt) begin
                tail <= tail + byte_tail_t'(1);
                // tail rolls over 1023 -> 0
                if (&tail) begin
                    wrap_count <= wrap_count + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            byte_r <= rx_byte;
        end
    end

    // same byte on every lane, be picks the one that lands
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mem.wdata.lanes[i] = byte_r;
        end
    end

    assign mem.req  = pending;
    assign mem.we   = 1'b1;
    assign mem.addr = tail[`TAIL_W-1:2];
    assign mem.be   = 4'b0001 << tail[1:0];

    // next byte must not arrive before the previous one is written
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |-> !pending);

endmodule

// ==== hdl/uart_bit_rx.sv ====
`timescale 1ns/1ns
`include "uart_mmio_macros.svh"

module uart_bit_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic [7:0] rx_byte,
    output logic       byte_valid
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_START = 3'd1;
    localparam logic [2:0] S_DATA  = 3'd2;
    localparam logic [2:0] S_STOP  = 3'd3;
    localparam logic [2:0] S_HOLD  = 3'd4;

    localparam logic [15:0] HALF_BIT = `UART_CLKS_PER_BIT / 16'd2 - 16'd1;
    localparam logic [15:0] FULL_BIT = `UART_CLKS_PER_BIT - 16'd1;

    logic [1:0]  rx_sync;
    logic        rx_s;
    logic [2:0]  state;
    logic [15:0] bit_cnt;
    logic [2:0]  bit_idx;

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync    <= 2'b11;
            state      <= S_IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], uart_rx};
            byte_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_s) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    // recheck the line at mid start bit, ignore glitches
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? S_IDLE : S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                S_STOP: begin
                    if (bit_cnt == FULL_BIT) begin
                        byte_valid <= rx_s;
                        // bad stop bit, wait for the line to go idle first
                        state      <= rx_s ? S_IDLE : S_HOLD;
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                S_HOLD: begin
                    if (rx_s) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // lsb first, sampled mid-bit
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_cnt == FULL_BIT) begin
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid);

endmodule

// ==== hdl/uart_mmio_macros.svh ====
`ifndef UART_MMIO_MACROS_SVH
`define UART_MMIO_MACROS_SVH

// clocks per serial bit
`define UART_CLKS_PER_BIT 16'd8

// ring buffer geometry, 1 KiB as 256 words of 4 bytes
`define BUF_WORDS 256
`define BUF_WORD_AW 8
`define TAIL_W 10

// status registers, byte addresses
`define REG_TAIL_ADDR 32'h0000_0400
`define REG_COUNT_ADDR 32'h0000_0404

`endif

// ==== hdl/uart_mmio_pkg.sv ====
`include "uart_mmio_macros.svh"

package uart_mmio_pkg;

    // byte position in the ring, wraps at 1024
    typedef logic [`TAIL_W-1:0] byte_tail_t;

    // word position in the buffer RAM
    typedef logic [`BUF_WORD_AW-1:0] word_idx_t;

    // number of times the tail wrapped
    typedef logic [31:0] wrap_count_t;

    // one buffer word
    // written lane by lane, read back whole
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } rx_word_u;

endpackage

// ==== hdl/uart_rx_mmio.sv ====
`timescale 1ns/1ns

module uart_rx_mmio import uart_mmio_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        uart_rx,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_wdata,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_rdata,
    output logic        wb_ack
);

    logic [7:0]  rx_byte;
    logic        byte_valid;
    byte_tail_t  tail;
    wrap_count_t wrap_count;
    logic        ram_en;
    logic        ram_we;
    word_idx_t   ram_addr;
    logic [3:0]  ram_be;
    rx_word_u    ram_wdata;
    logic [31:0] ram_rdata;

    buf_mem_if rx_mem ();
    buf_mem_if host_mem ();

    uart_bit_rx bit_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .uart_rx    (uart_rx),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    rx_byte_packer packer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .mem        (rx_mem.requester),
        .tail       (tail),
        .wrap_count (wrap_count)
    );

    host_wb_port host_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_sel     (wb_sel),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .mem        (host_mem.requester),
        .tail       (tail),
        .wrap_count (wrap_count)
    );

    buffer_arbiter arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_side   (rx_mem.arbiter),
        .host_side (host_mem.arbiter),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    rx_buffer_ram ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// ==== verification/uart_rx_mmio_tb.sv ====
`timescale 1ns/1ns
`include "uart_mmio_macros.svh"

module uart_rx_mmio_tb import uart_mmio_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int BIT_CLKS     = `UART_CLKS_PER_BIT;
    localparam int RING_BYTES   = `BUF_WORDS * 4;
    // 7 + 1 + rest up to 1030, plus the bad frame
    localparam int TOTAL_FRAMES = 1031;
    localparam int WATCHDOG_NS  =
        TOTAL_FRAMES * 10 * BIT_CLKS * CLK_PERIOD * 3 / 2 + 50000;
    localparam int ACK_LIMIT    = 50;

    logic        clk;
    logic        rst_n;
    logic        uart_rx;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [3:0]  wb_sel;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    logic [7:0]  sent_q[$];
    logic [31:0] rd_addr;
    logic [31:0] rd_data;
    event        read_done;
    int          checks;
    int          errors;
    logic        frame_done;

    uart_rx_mmio uart_rx_mmio_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rx  (uart_rx),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_sel   (wb_sel),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected register or buffer word after the bytes in bytes_q
    function automatic logic [31:0] expected_value(input logic [7:0] bytes_q[$],
                                                   input logic [31:0] addr);
        logic [31:0] word;
        int          idx;
        word = '0;
        idx  = addr[9:2];
        if (addr == `REG_TAIL_ADDR) begin
            return 32'(bytes_q.size() % RING_BYTES);
        end
        if (addr == `REG_COUNT_ADDR) begin
            return 32'(bytes_q.size() / RING_BYTES);
        end
        for (int n = 0; n < bytes_q.size(); n++) begin
            // later bytes overwrite earlier ones after a wrap
            if ((n % RING_BYTES) / 4 == idx) begin
                word[(n % 4) * 8 +: 8] = bytes_q[n];
            end
        end
        return word;
    endfunction

    task automatic check_word(input string name, input rx_word_u exp, input rx_word_u act);
        checks++;
        if (act.word !== exp.word) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp.word, act.word);
        end
    endtask

    task automatic check_tail(input string name, input byte_tail_t exp, input byte_tail_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input wrap_count_t exp,
                               input wrap_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // checks every completed host read against the reference
    always @(read_done) begin : compare_reads
        rx_word_u exp_w;
        rx_word_u got_w;
        exp_w = expected_value(sent_q, rd_addr);
        got_w = rd_data;
        if (rd_addr == `REG_TAIL_ADDR) begin
            check_tail("wb_rdata (tail)", byte_tail_t'(exp_w.word), byte_tail_t'(got_w.word));
            // status word bits above the tail
            checks++;
            if (got_w.word[31:`TAIL_W] !== exp_w.word[31:`TAIL_W]) begin
                errors++;
                $display("FAILED at %0t ns: wb_rdata[31:%0d] (tail) expected %h, got %h",
                         $time, `TAIL_W, exp_w.word[31:`TAIL_W], got_w.word[31:`TAIL_W]);
            end
        end else if (rd_addr == `REG_COUNT_ADDR) begin
            check_count("wb_rdata (wrap count)", exp_w.word, got_w.word);
        end else begin
            check_word($sformatf("wb_rdata (word %0d)", rd_addr[9:2]), exp_w, got_w);
        end
    end

    // start bit, 8 data bits lsb first, stop bit, one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [10:0] bits;
        bits = {1'b1, stop_bit, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            #1 uart_rx = bits[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
        if (stop_bit) begin
            sent_q.push_back(data);
        end
    endtask

    task automatic send_random(input int count);
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            b = 8'($urandom());
            send_frame(b, 1'b1);
        end
    endtask

    // one classic cycle, held until ack is seen at a rising edge
    task automatic wb_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] data);
        logic got_ack;
        got_ack = 1'b0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_wdata = data;
        wb_sel   = 4'hf;
        for (int i = 0; i < ACK_LIMIT && !got_ack; i++) begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                got_ack = 1'b1;
                if (!we) begin
                    rd_addr = addr;
                    rd_data = wb_rdata;
                    -> read_done;
                end
            end
        end
        if (!got_ack) begin
            errors++;
            $display("no acknowledge from the DUT for %s at address %h",
                     we ? "write" : "read", addr);
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [31:0] addr);
        wb_access(1'b0, addr, 32'h0);
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
        checks++;
        wb_access(1'b1, addr, data);
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "errors");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        int  errs;
        logic [7:0] b;
        void'($urandom(13268));
        checks     = 0;
        errors     = 0;
        frame_done = 1'b0;
        rst_n      = 1'b0;
        uart_rx    = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_wdata   = '0;
        wb_sel     = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        errs = errors;
        wb_read(`REG_TAIL_ADDR);
        wb_read(`REG_COUNT_ADDR);
        wb_read(32'h000);
        wb_read(32'h004);
        wb_read(32'h200);
        wb_read(32'h3fc);
        finish_test(1, "reset state", errs);

        errs = errors;
        send_random(7);
        wb_read(`REG_TAIL_ADDR);
        wb_read(`REG_COUNT_ADDR);
        wb_read(32'h000);
        wb_read(32'h004);
        finish_test(2, "seven bytes", errs);

        // reads of word 0 overlap the packer write near the stop bit
        errs = errors;
        b = 8'($urandom());
        fork
            begin
                send_frame(b, 1'b1);
                frame_done = 1'b1;
            end
            begin
                repeat (79) @(posedge clk);
                while (!frame_done) begin
                    wb_read(32'h000);
                end
            end
        join
        wb_read(32'h004);
        wb_read(`REG_TAIL_ADDR);
        finish_test(3, "read during write", errs);

        errs = errors;
        while (sent_q.size() < 1030) begin
            send_random(1);
        end
        wb_read(`REG_TAIL_ADDR);
        wb_read(`REG_COUNT_ADDR);
        wb_read(32'h000);
        wb_read(32'h004);
        wb_read(32'h3fc);
        finish_test(4, "ring wrap", errs);

        errs = errors;
        wb_write(`REG_TAIL_ADDR, 32'h0000_0123);
        wb_write(`REG_COUNT_ADDR, 32'h0000_0077);
        wb_write(32'h000, 32'hdead_beef);
        wb_read(`REG_TAIL_ADDR);
        wb_read(`REG_COUNT_ADDR);
        wb_read(32'h000);
        finish_test(5, "host writes ignored", errs);

        errs = errors;
        b = 8'($urandom());
        send_frame(b, 1'b0);
        wb_read(`REG_TAIL_ADDR);
        wb_read(`REG_COUNT_ADDR);
        finish_test(6, "bad stop bit", errs);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
